// File: source/execUnit_consts.svh
`ifndef EXECUNIT_CONSTS_SVH
`define EXECUNIT_CONSTS_SVH

//////////////////////////////////////////////////
// datapath sizing
//////////////////////////////////////////////////
`define DATA_WIDTH 32 // operand and result width
`define DIV_CYCLES 32 // one quotient bit per cycle

// main decoder opcode
`define ALUOP_MEM   2'b00 // lw, sw, lb, sb, lh, sh
`define ALUOP_ITYPE 2'b01 // immediates and branches
`define ALUOP_RTYPE 2'b10 // funct selects

//////////////////////////////////////////////////
// op field, used under ALUOP_ITYPE
//////////////////////////////////////////////////
`define OP_BCOND 6'b000001 // bgez, bltz
`define OP_BEQ   6'b000100
`define OP_BNE   6'b000101
`define OP_BLEZ  6'b000110
`define OP_BGTZ  6'b000111
`define OP_ADDI  6'b001000
`define OP_ADDIU 6'b001001
`define OP_SLTI  6'b001010
`define OP_SLTIU 6'b001011
`define OP_ANDI  6'b001100
`define OP_ORI   6'b001101
`define OP_XORI  6'b001110
`define OP_LUI   6'b001111

//////////////////////////////////////////////////
// funct field, used under ALUOP_RTYPE
//////////////////////////////////////////////////
`define FUNCT_SLL   6'b000000
`define FUNCT_SRL   6'b000010
`define FUNCT_SRA   6'b000011
`define FUNCT_SEB   6'b000101
`define FUNCT_SEH   6'b000110
`define FUNCT_ROTR  6'b000111 // rotr and rotrv share it
`define FUNCT_MOVZ  6'b001010
`define FUNCT_MOVN  6'b001011
`define FUNCT_MFHI  6'b010000
`define FUNCT_MTHI  6'b010001
`define FUNCT_MFLO  6'b010010
`define FUNCT_MTLO  6'b010011
`define FUNCT_MULT  6'b011000
`define FUNCT_MULTU 6'b011001
`define FUNCT_DIV   6'b011010
`define FUNCT_DIVU  6'b011011
`define FUNCT_ADD   6'b100000
`define FUNCT_ADDU  6'b100001
`define FUNCT_SUB   6'b100010
`define FUNCT_SUBU  6'b100011
`define FUNCT_AND   6'b100100
`define FUNCT_OR    6'b100101
`define FUNCT_XOR   6'b100110
`define FUNCT_NOR   6'b100111
`define FUNCT_SLT   6'b101010
`define FUNCT_SLTU  6'b101011
`define FUNCT_MADD  6'b101100
`define FUNCT_MSUB  6'b101101

`endif

// File: source/execPkg.sv
package execPkg;

    //////////////////////////////////////////////////
    // ALU control codes
    //////////////////////////////////////////////////
    typedef enum logic [4:0] {
        ctlAnd   = 5'd0,
        ctlOr    = 5'd1,
        ctlAdd   = 5'd2,  // also loads, stores, addi
        ctlAddu  = 5'd3,
        ctlSub   = 5'd4,  // also every branch compare
        ctlSubu  = 5'd5,
        ctlSll   = 5'd6,
        ctlSrl   = 5'd7,
        ctlMult  = 5'd8,
        ctlMultu = 5'd9,
        ctlSlt   = 5'd10,
        ctlSltu  = 5'd11,
        ctlNor   = 5'd12,
        ctlXor   = 5'd13,
        ctlRotr  = 5'd14,
        ctlDiv   = 5'd15, // multi-cycle
        ctlDivu  = 5'd16, // multi-cycle
        ctlMadd  = 5'd17,
        ctlMsub  = 5'd18,
        ctlMovz  = 5'd19,
        ctlMovn  = 5'd20,
        ctlMfhi  = 5'd21,
        ctlMthi  = 5'd22,
        ctlMflo  = 5'd23,
        ctlMtlo  = 5'd24,
        ctlLui   = 5'd25,
        ctlSeb   = 5'd26,
        ctlSeh   = 5'd27,
        ctlSra   = 5'd28, // split off from srl
        ctlNop   = 5'd31  // unknown encoding, never written back
    } aluCtl_t;

endpackage

// File: source/aluControl.sv
`include "execUnit_consts.svh"

module aluControl
    import execPkg::*;
(
    input  logic [1:0] aluOp, // from main decoder
    input  logic [5:0] op,    // instruction bits 31:26
    input  logic [5:0] funct, // instruction bits 5:0
    output aluCtl_t    ctl
);

    always_comb
    begin
        ctl = ctlNop; // unlisted encodings fall here
        case (aluOp)
            `ALUOP_MEM:
            begin
                ctl = ctlAdd; // address calc
            end
            `ALUOP_ITYPE:
            begin
                case (op)
                    `OP_ADDI:  ctl = ctlAdd;
                    `OP_ADDIU: ctl = ctlAdd;
                    `OP_ANDI:  ctl = ctlAnd;
                    `OP_ORI:   ctl = ctlOr;
                    `OP_XORI:  ctl = ctlXor;
                    `OP_LUI:   ctl = ctlLui;
                    `OP_SLTI:  ctl = ctlSlt;
                    `OP_SLTIU: ctl = ctlSltu;

                    // branch compares for a decision made outside
                    `OP_BEQ:   ctl = ctlSub;
                    `OP_BCOND: ctl = ctlSub; // bgez, bltz
                    `OP_BGTZ:  ctl = ctlSub;
                    `OP_BLEZ:  ctl = ctlSub;
                    `OP_BNE:   ctl = ctlSub;
                    default:   ctl = ctlNop;
                endcase
            end
            `ALUOP_RTYPE:
            begin
                case (funct)
                    // shifts
                    `FUNCT_SLL:   ctl = ctlSll;
                    `FUNCT_SRL:   ctl = ctlSrl;
                    `FUNCT_SRA:   ctl = ctlSra; // own code now
                    `FUNCT_ROTR:  ctl = ctlRotr;

                    // sign extension
                    `FUNCT_SEB:   ctl = ctlSeb;
                    `FUNCT_SEH:   ctl = ctlSeh;

                    // conditional moves
                    `FUNCT_MOVZ:  ctl = ctlMovz;
                    `FUNCT_MOVN:  ctl = ctlMovn;

                    // HI/LO access
                    `FUNCT_MFHI:  ctl = ctlMfhi;
                    `FUNCT_MTHI:  ctl = ctlMthi;
                    `FUNCT_MFLO:  ctl = ctlMflo;
                    `FUNCT_MTLO:  ctl = ctlMtlo;

                    // multiply and divide
                    `FUNCT_MULT:  ctl = ctlMult;
                    `FUNCT_MULTU: ctl = ctlMultu;
                    `FUNCT_DIV:   ctl = ctlDiv;
                    `FUNCT_DIVU:  ctl = ctlDivu;
                    `FUNCT_MADD:  ctl = ctlMadd;
                    `FUNCT_MSUB:  ctl = ctlMsub;

                    // arithmetic
                    `FUNCT_ADD:   ctl = ctlAdd;
                    `FUNCT_ADDU:  ctl = ctlAddu;
                    `FUNCT_SUB:   ctl = ctlSub;
                    `FUNCT_SUBU:  ctl = ctlSubu;

                    // logic
                    `FUNCT_AND:   ctl = ctlAnd;
                    `FUNCT_OR:    ctl = ctlOr;
                    `FUNCT_XOR:   ctl = ctlXor;
                    `FUNCT_NOR:   ctl = ctlNor;

                    // compares
                    `FUNCT_SLT:   ctl = ctlSlt;
                    `FUNCT_SLTU:  ctl = ctlSltu;
                    default:      ctl = ctlNop;
                endcase
            end
            default:
            begin
                ctl = ctlNop; // opcode 11 not used
            end
        endcase
    end

endmodule

// File: source/alu.sv
`include "execUnit_consts.svh"

module alu
    import execPkg::*;
(
    input  aluCtl_t                ctl,
    input  logic [`DATA_WIDTH-1:0] srcA,
    input  logic [`DATA_WIDTH-1:0] srcB,
    input  logic [4:0]             shamt,     // instruction shift amount
    output logic [`DATA_WIDTH-1:0] aluResult,
    output logic                   zero,
    output logic                   moveWrite  // movz/movn condition met
);

    localparam int dataW = `DATA_WIDTH;
    localparam int halfW = `DATA_WIDTH / 2;

    logic signed [dataW-1:0] sraVal;
    logic [2*dataW-1:0]      rotWide;
    logic                    ltSigned;
    logic                    ltUnsigned;
    logic                    srcBZero;

    //////////////////////////////////////////////////
    // shared helpers
    //////////////////////////////////////////////////
    assign sraVal     = $signed(srcB) >>> shamt;       // keeps the sign bit
    assign rotWide    = {srcB, srcB} >> srcA[4:0];     // low half is the rotation
    assign ltSigned   = $signed(srcA) < $signed(srcB);
    assign ltUnsigned = srcA < srcB;
    assign srcBZero   = (srcB == '0);

    //////////////////////////////////////////////////
    // result select
    //////////////////////////////////////////////////
    always_comb
    begin
        aluResult = '0;       // HI/LO codes and nop give zero here
        moveWrite = 1'b0;
        case (ctl)
            ctlAnd:  aluResult = srcA & srcB;
            ctlOr:   aluResult = srcA | srcB;
            ctlXor:  aluResult = srcA ^ srcB;
            ctlNor:  aluResult = ~(srcA | srcB);

            ctlAdd:  aluResult = srcA + srcB;  // no overflow trap
            ctlAddu: aluResult = srcA + srcB;
            ctlSub:  aluResult = srcA - srcB;  // branch compare too
            ctlSubu: aluResult = srcA - srcB;

            ctlSlt:  aluResult = {{(dataW-1){1'b0}}, ltSigned};
            ctlSltu: aluResult = {{(dataW-1){1'b0}}, ltUnsigned};

            ctlSll:  aluResult = srcB << shamt;
            ctlSrl:  aluResult = srcB >> shamt;
            ctlSra:  aluResult = sraVal;
            ctlRotr: aluResult = rotWide[dataW-1:0];

            ctlLui:  aluResult = {srcB[halfW-1:0], {halfW{1'b0}}};
            ctlSeb:  aluResult = {{(dataW-8){srcB[7]}}, srcB[7:0]};
            ctlSeh:  aluResult = {{(dataW-halfW){srcB[halfW-1]}}, srcB[halfW-1:0]};

            ctlMovz:
            begin
                aluResult = srcA;
                moveWrite = srcBZero;   // rt == 0
            end
            ctlMovn:
            begin
                aluResult = srcA;
                moveWrite = !srcBZero;  // rt != 0
            end
            default:
            begin
                aluResult = '0;
                moveWrite = 1'b0;
            end
        endcase
    end

    assign zero = (aluResult == '0);

endmodule

// File: source/hiLoUnit.sv
`include "execUnit_consts.svh"

module hiLoUnit
    import execPkg::*;
(
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   start,    // accepted issue
    input  aluCtl_t                ctl,
    input  logic [`DATA_WIDTH-1:0] srcA,
    input  logic [`DATA_WIDTH-1:0] srcB,
    output logic [`DATA_WIDTH-1:0] hiLoData, // mfhi/mflo read
    output logic                   busy,     // divider running
    output logic                   divDone   // last divide step this cycle
);

    localparam int dataW  = `DATA_WIDTH;
    localparam int countW = $clog2(`DIV_CYCLES);

    logic [dataW-1:0]          hi;
    logic [dataW-1:0]          lo;
    logic [countW-1:0]         divCount;
    logic [dataW-1:0]          divRem;     // partial remainder
    logic [dataW-1:0]          divQuo;     // dividend shifts out as quotient shifts in
    logic [dataW-1:0]          divisorMag;
    logic                      quoNeg;
    logic                      remNeg;
    logic                      divZero;

    logic signed [2*dataW-1:0] sProd;
    logic [2*dataW-1:0]        uProd;
    logic [2*dataW-1:0]        maddSum;
    logic [2*dataW-1:0]        msubDiff;
    logic                      signedDiv;
    logic                      isDivOp;
    logic [dataW-1:0]          magA;
    logic [dataW-1:0]          magB;
    logic [dataW:0]            remShift;
    logic [dataW:0]            trial;
    logic [dataW-1:0]          nextRem;
    logic [dataW-1:0]          nextQuo;
    logic [dataW-1:0]          finalRem;
    logic [dataW-1:0]          finalQuo;
    logic                      lastStep;

    //////////////////////////////////////////////////
    // multiply family
    //////////////////////////////////////////////////
    assign sProd    = $signed(srcA) * $signed(srcB);
    assign uProd    = {{dataW{1'b0}}, srcA} * {{dataW{1'b0}}, srcB};
    assign maddSum  = {hi, lo} + sProd;
    assign msubDiff = {hi, lo} - sProd;

    //////////////////////////////////////////////////
    // restoring divider
    //////////////////////////////////////////////////
    assign isDivOp   = (ctl == ctlDiv) || (ctl == ctlDivu);
    assign signedDiv = (ctl == ctlDiv);
    assign magA      = (signedDiv && srcA[dataW-1]) ? -srcA : srcA;
    assign magB      = (signedDiv && srcB[dataW-1]) ? -srcB : srcB;

    assign remShift = {divRem, divQuo[dataW-1]};      // bring down next bit
    assign trial    = remShift - {1'b0, divisorMag};
    assign nextRem  = trial[dataW] ? remShift[dataW-1:0] : trial[dataW-1:0]; // restore
    assign nextQuo  = {divQuo[dataW-2:0], ~trial[dataW]};

    assign lastStep = (divCount == countW'(`DIV_CYCLES - 1));
    assign divDone  = busy && lastStep;

    // remainder follows the dividend sign so /0 gives the dividend back
    assign finalRem = remNeg ? -nextRem : nextRem;
    assign finalQuo = divZero ? '1 : (quoNeg ? -nextQuo : nextQuo);

    // divider datapath
    always_ff @(posedge clk)
    begin
        if (start && isDivOp)
        begin
            divRem     <= '0;
            divQuo     <= magA;
            divisorMag <= magB;
            quoNeg     <= signedDiv && (srcA[dataW-1] ^ srcB[dataW-1]);
            remNeg     <= signedDiv && srcA[dataW-1];
            divZero    <= (srcB == '0);
        end
        else if (busy)
        begin
            divRem <= nextRem;
            divQuo <= nextQuo;
        end
    end

    //////////////////////////////////////////////////
    // HI/LO and divider control
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            hi       <= '0;
            lo       <= '0;
            busy     <= 1'b0;
            divCount <= '0;
        end
        else if (busy)
        begin
            divCount <= divCount + 1'b1;
            if (lastStep)
            begin
                busy <= 1'b0;
                hi   <= finalRem;  // remainder
                lo   <= finalQuo;  // quotient
            end
        end
        else if (start)
        begin
            case (ctl)
                ctlMult:  {hi, lo} <= sProd;
                ctlMultu: {hi, lo} <= uProd;
                ctlMadd:  {hi, lo} <= maddSum;
                ctlMsub:  {hi, lo} <= msubDiff;
                ctlMthi:  hi <= srcA;
                ctlMtlo:  lo <= srcA;
                ctlDiv, ctlDivu:
                begin
                    busy     <= 1'b1;
                    divCount <= '0;
                end
                default:  ;        // nothing to update
            endcase
        end
    end

    assign hiLoData = (ctl == ctlMfhi) ? hi : lo;

endmodule

// File: source/execUnit.sv
`include "execUnit_consts.svh"

module execUnit
    import execPkg::*;
(
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   issue,       // one-cycle strobe
    input  logic [1:0]             aluOp,
    input  logic [5:0]             op,
    input  logic [5:0]             funct,
    input  logic [4:0]             shamt,
    input  logic [`DATA_WIDTH-1:0] srcA,
    input  logic [`DATA_WIDTH-1:0] srcB,
    output logic [`DATA_WIDTH-1:0] result,
    output logic                   resultValid, // one-cycle pulse
    output logic                   writeEn,     // register file may write
    output logic                   zero,
    output logic                   busy
);

    aluCtl_t                ctl;
    logic                   accept;
    logic                   isDiv;
    logic                   readsHiLo;
    logic                   wbEn;
    logic                   moveWrite;
    logic                   aluZero;
    logic                   divDone;
    logic [`DATA_WIDTH-1:0] aluResult;
    logic [`DATA_WIDTH-1:0] hiLoData;
    logic [`DATA_WIDTH-1:0] selResult;
    logic                   selZero;

    aluControl u_aluControl (
        .aluOp (aluOp),
        .op    (op),
        .funct (funct),
        .ctl   (ctl)
    );

    alu u_alu (
        .ctl       (ctl),
        .srcA      (srcA),
        .srcB      (srcB),
        .shamt     (shamt),
        .aluResult (aluResult),
        .zero      (aluZero),
        .moveWrite (moveWrite)
    );

    hiLoUnit u_hiLoUnit (
        .clk      (clk),
        .arstN    (arstN),
        .start    (accept),
        .ctl      (ctl),
        .srcA     (srcA),
        .srcB     (srcB),
        .hiLoData (hiLoData),
        .busy     (busy),
        .divDone  (divDone)
    );

    assign accept    = issue && !busy;                 // dropped while dividing
    assign isDiv     = (ctl == ctlDiv) || (ctl == ctlDivu);
    assign readsHiLo = (ctl == ctlMfhi) || (ctl == ctlMflo);
    assign selResult = readsHiLo ? hiLoData : aluResult;
    assign selZero   = readsHiLo ? (hiLoData == '0) : aluZero;

    // write-back rule
    always_comb
    begin
        case (ctl)
            ctlMult, ctlMultu, ctlMadd, ctlMsub: wbEn = 1'b0;
            ctlMthi, ctlMtlo, ctlDiv, ctlDivu:   wbEn = 1'b0;
            ctlNop:                              wbEn = 1'b0;
            ctlMovz, ctlMovn:                    wbEn = moveWrite;
            default:                             wbEn = 1'b1;
        endcase
    end

    //////////////////////////////////////////////////
    // output registers
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            resultValid <= 1'b0;
            writeEn     <= 1'b0;
        end
        else
        begin
            resultValid <= (accept && !isDiv) || divDone;  // divide ends with busy
            writeEn     <= accept && !isDiv && wbEn;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept && !isDiv)
        begin
            result <= selResult;
            zero   <= selZero;
        end
    end

endmodule

// File: dv/execTb.sv
`include "execUnit_consts.svh"

module execTb
    import execPkg::*;
();

    localparam int clkPeriod      = 20;
    localparam int randIters      = 16;                 // per code in the random sweeps
    localparam int hiLoRounds     = 6;
    localparam int opLimit        = `DIV_CYCLES + 4;    // longest wait for one pulse
    localparam int opBound        = 19 * randIters + 24 * hiLoRounds + 60;
    localparam int watchdogCycles = 10 + opBound * opLimit + 100;

    logic                   clk;
    logic                   arstN;
    logic                   issue;
    logic [1:0]             aluOp;
    logic [5:0]             op;
    logic [5:0]             funct;
    logic [4:0]             shamt;
    logic [`DATA_WIDTH-1:0] srcA;
    logic [`DATA_WIDTH-1:0] srcB;
    logic [`DATA_WIDTH-1:0] result;
    logic                   resultValid;
    logic                   writeEn;
    logic                   zero;
    logic                   busy;

    logic [31:0] expResult;     // model view of the outstanding instruction
    logic        expWriteEn;
    logic        expCheck;      // result and zero defined for this code
    logic        expDiv;
    logic        pending;       // one pulse owed
    logic        dropIssue;     // issue made during a divide
    logic        accepted;      // issue taken at the last edge
    int          busyCount;
    int          valueErrors;
    int          protocolErrors;
    int          opCount;
    logic [31:0] modelHi;
    logic [31:0] modelLo;
    logic [31:0] rngState;

    execUnit u_execUnit (
        .clk         (clk),
        .arstN       (arstN),
        .issue       (issue),
        .aluOp       (aluOp),
        .op          (op),
        .funct       (funct),
        .shamt       (shamt),
        .srcA        (srcA),
        .srcB        (srcB),
        .result      (result),
        .resultValid (resultValid),
        .writeEn     (writeEn),
        .zero        (zero),
        .busy        (busy)
    );

    always #(clkPeriod / 2) clk = ~clk;

    //////////////////////////////////////////////////
    // random source and reporting
    //////////////////////////////////////////////////
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [31:0] randWord();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    task automatic reportValue(input string name, input logic [31:0] expV,
                               input logic [31:0] actV);
        valueErrors++;
        $display("[FAIL] time %0t %s expected %h actual %h", $time, name, expV, actV);
    endtask

    task automatic reportEvent(input string msg);
        protocolErrors++;
        $display("time %0t: %s", $time, msg);
    endtask

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////
    function automatic logic [31:0] modelValue(input aluCtl_t c, input logic [31:0] a,
                                               input logic [31:0] b, input logic [4:0] sh);
        case (c)
            ctlAnd:           return a & b;
            ctlOr:            return a | b;
            ctlXor:           return a ^ b;
            ctlNor:           return ~(a | b);
            ctlAdd, ctlAddu:  return a + b;
            ctlSub, ctlSubu:  return a - b;          // branches compare by subtracting
            ctlSlt:           return {31'b0, $signed(a) < $signed(b)};
            ctlSltu:          return {31'b0, a < b};
            ctlSll:           return b << sh;
            ctlSrl:           return b >> sh;
            ctlSra:           return $signed(b) >>> sh;
            ctlRotr:          return (b >> a[4:0]) | (b << (32 - a[4:0]));
            ctlLui:           return {b[15:0], 16'h0000};
            ctlSeb:           return {{24{b[7]}}, b[7:0]};
            ctlSeh:           return {{16{b[15]}}, b[15:0]};
            ctlMovz, ctlMovn: return a;
            ctlMfhi:          return modelHi;
            ctlMflo:          return modelLo;
            default:          return 32'h0;
        endcase
    endfunction

    function automatic logic producesValue(input aluCtl_t c);
        case (c)
            ctlMult, ctlMultu, ctlMadd, ctlMsub: return 1'b0;
            ctlMthi, ctlMtlo, ctlDiv, ctlDivu:   return 1'b0;
            ctlNop:                              return 1'b0;
            default:                             return 1'b1;
        endcase
    endfunction

    function automatic logic modelWrite(input aluCtl_t c, input logic [31:0] b);
        if (c == ctlMovz)
            return b == 32'h0;
        if (c == ctlMovn)
            return b != 32'h0;
        return producesValue(c);
    endfunction

    task automatic updateHiLo(input aluCtl_t c, input logic [31:0] a, input logic [31:0] b);
        logic signed [63:0] sProd;
        sProd = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        case (c)
            ctlMult:  {modelHi, modelLo} = sProd;
            ctlMultu: {modelHi, modelLo} = {32'h0, a} * {32'h0, b};
            ctlMadd:  {modelHi, modelLo} = {modelHi, modelLo} + sProd;
            ctlMsub:  {modelHi, modelLo} = {modelHi, modelLo} - sProd;
            ctlMthi:  modelHi = a;
            ctlMtlo:  modelLo = a;
            ctlDiv, ctlDivu:
            begin
                if (b == 32'h0)
                begin
                    modelHi = a;            // dividend back
                    modelLo = 32'hffffffff;
                end
                else if (c == ctlDiv)
                begin
                    modelLo = $signed(a) / $signed(b);   // truncates toward zero
                    modelHi = $signed(a) % $signed(b);
                end
                else
                begin
                    modelLo = a / b;
                    modelHi = a % b;
                end
            end
            default: ;
        endcase
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////
    task automatic issueOp(input logic [1:0] ao, input logic [5:0] o, input logic [5:0] f,
                           input aluCtl_t c, input logic [31:0] a, input logic [31:0] b,
                           input logic [4:0] sh, input int dropAt);
        int waited;
        @(negedge clk);
        aluOp      = ao;
        op         = o;
        funct      = f;
        shamt      = sh;
        srcA       = a;
        srcB       = b;
        issue      = 1'b1;
        expResult  = modelValue(c, a, b, sh);  // mfhi/mflo read before this op's update
        expWriteEn = modelWrite(c, b);
        expCheck   = producesValue(c);
        expDiv     = (c == ctlDiv) || (c == ctlDivu);
        pending    = 1'b1;
        opCount++;
        updateHiLo(c, a, b);
        @(negedge clk);
        issue  = 1'b0;
        waited = 1;
        while (!resultValid && waited < opLimit)
        begin
            if (waited == dropAt)
            begin
                funct     = `FUNCT_MTHI;     // arrives while busy and must be ignored
                srcA      = randWord();
                issue     = 1'b1;
                dropIssue = 1'b1;
            end
            @(negedge clk);
            issue     = 1'b0;
            dropIssue = 1'b0;
            waited++;
        end
        if (!resultValid)
            reportEvent($sformatf("no resultValid pulse within %0d cycles of issue", opLimit));
        pending = 1'b0;
    endtask

    task automatic rType(input logic [5:0] f, input aluCtl_t c,
                         input logic [31:0] a, input logic [31:0] b);
        issueOp(`ALUOP_RTYPE, 6'd0, f, c, a, b, 5'd0, 0);
    endtask

    task automatic readHiLo();
        rType(`FUNCT_MFHI, ctlMfhi, randWord(), 32'h0);
        rType(`FUNCT_MFLO, ctlMflo, randWord(), 32'h0);
    endtask

    task automatic randomOp(input logic [1:0] ao, input logic [5:0] o, input logic [5:0] f,
                            input aluCtl_t c, input int n);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        for (int i = 0; i < n; i++)
        begin
            a = randWord();
            b = randWord();
            r = randWord();
            if (i == 0)
                b = a;                   // equal operands give zero for sub and xor
            if (i == 1)
                b = 32'h0;               // movz taken
            if (i == 2)
                b = b | 32'h80008080;    // negative word, byte and half
            issueOp(ao, o, f, c, a, b, r[4:0], 0);
        end
    endtask

    task automatic hiLoSequence();
        logic [31:0] a;
        logic [31:0] b;
        for (int i = 0; i < hiLoRounds; i++)
        begin
            a = randWord();
            b = randWord();
            rType(`FUNCT_MTHI, ctlMthi, a, b);
            rType(`FUNCT_MTLO, ctlMtlo, b, a);
            readHiLo();
            rType(`FUNCT_MULT, ctlMult, a, b);
            readHiLo();
            rType(`FUNCT_MULTU, ctlMultu, a, b);
            readHiLo();
            rType(`FUNCT_MADD, ctlMadd, b, a);
            readHiLo();
            rType(`FUNCT_MSUB, ctlMsub, randWord(), randWord());
            readHiLo();
        end
    endtask

    task automatic divideSequence();
        logic [31:0] a;
        logic [31:0] b;
        for (int i = 0; i < hiLoRounds; i++)
        begin
            a = randWord();
            b = randWord() >> (i * 4);   // smaller divisors give longer quotients
            issueOp(`ALUOP_RTYPE, 6'd0, `FUNCT_DIV, ctlDiv, a, b, 5'd0, 5);
            readHiLo();
            issueOp(`ALUOP_RTYPE, 6'd0, `FUNCT_DIVU, ctlDivu, a, b, 5'd0, 0);
            readHiLo();
        end
        a = randWord();
        issueOp(`ALUOP_RTYPE, 6'd0, `FUNCT_DIV, ctlDiv, a, 32'h0, 5'd0, 9);
        readHiLo();
        issueOp(`ALUOP_RTYPE, 6'd0, `FUNCT_DIVU, ctlDivu, a, 32'h0, 5'd0, 0);
        readHiLo();
    endtask

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////
    always @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            accepted  <= 1'b0;
            busyCount <= 0;
        end
        else
        begin
            accepted <= issue && !dropIssue;  // issues the DUT has to take
            if (issue && !dropIssue)
                busyCount <= 0;
            else if (busy)
                busyCount <= busyCount + 1;
        end
    end

    // sampled on the falling edge, where outputs are stable
    pulseOwed: assert property (@(negedge clk) disable iff (!arstN)
        resultValid |-> pending)
        else reportEvent("resultValid pulsed with no instruction outstanding");

    pulseTiming: assert property (@(negedge clk) disable iff (!arstN)
        accepted && !expDiv |-> resultValid)
        else reportEvent("resultValid missing one cycle after issue");

    divStart: assert property (@(negedge clk) disable iff (!arstN)
        accepted && expDiv |-> busy && !resultValid)
        else reportEvent("busy did not rise after divide issue");

    divLength: assert property (@(negedge clk) disable iff (!arstN)
        resultValid && expDiv |-> busyCount == `DIV_CYCLES)
        else reportValue("busy cycles", `DIV_CYCLES, busyCount);

    writeEnCheck: assert property (@(negedge clk) disable iff (!arstN)
        resultValid |-> writeEn == expWriteEn)
        else reportValue("writeEn", expWriteEn, writeEn);

    writeEnQuiet: assert property (@(negedge clk) disable iff (!arstN)
        !resultValid |-> !writeEn)
        else reportEvent("writeEn high without resultValid");

    resultCheck: assert property (@(negedge clk) disable iff (!arstN)
        resultValid && expCheck |-> result == expResult)
        else reportValue("result", expResult, result);

    zeroCheck: assert property (@(negedge clk) disable iff (!arstN)
        resultValid && expCheck |-> zero == (expResult == 32'h0))
        else reportValue("zero", expResult == 32'h0, zero);

    initial
    begin
        #(watchdogCycles * clkPeriod);
        $display("watchdog expired after %0d cycles, run did not finish", watchdogCycles);
        $display("TB FAILED");
        $finish;
    end

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////
    initial
    begin
        clk            = 1'b0;
        arstN          = 1'b0;
        issue          = 1'b0;
        aluOp          = 2'b00;
        op             = 6'd0;
        funct          = 6'd0;
        shamt          = 5'd0;
        srcA           = '0;
        srcB           = '0;
        expResult      = 32'h0;
        expWriteEn     = 1'b0;
        expCheck       = 1'b0;
        expDiv         = 1'b0;
        pending        = 1'b0;
        dropIssue      = 1'b0;
        valueErrors    = 0;
        protocolErrors = 0;
        opCount        = 0;
        modelHi        = 32'h0;
        modelLo        = 32'h0;
        rngState       = 32'd38;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        resetIdle: assert (!resultValid && !writeEn && !busy)
            else reportEvent("outputs not idle after reset");
        readHiLo();                      // both cleared by reset

        // R-type arithmetic, logic, compares
        randomOp(`ALUOP_RTYPE, 6'd0, `FUNCT_ADD, ctlAdd, randIters);
        randomOp(`ALUOP_RTYPE, 6'd0, `FUNCT_ADDU, ctlAddu, randIters);
        randomOp(`ALUOP_RTYPE, 6'd0, `FUNCT_SUB, ctlSub, randIters);
        randomOp(`ALUOP_RTYPE, 6'd0, `FUNCT_SUBU, ctlSubu, randIters);
        randomOp(`ALUOP_RTYPE, 6'd0, `FUNCT_AND, ctlAnd, randIters);
        randomOp(`ALUOP_RTYPE, 6'd0, `FUNCT_OR, ctlOr, randIters);
        randomOp(`ALUOP_RTYPE, 6'd0, `FUNCT_XOR, ctlXor, randIters);
        randomOp(`ALUOP_RTYPE, 6'd0, `FUNCT_NOR, ctlNor, randIters);
        randomOp(`ALUOP_RTYPE, 6'd0, `FUNCT_SLT, ctlSlt, randIters);
        randomOp(`ALUOP_RTYPE, 6'd0, `FUNCT_SLTU, ctlSltu, randIters);

        // memory opcode, I-type, branches, unknown encodings
        randomOp(`ALUOP_MEM, 6'b100011, 6'd0, ctlAdd, 2);   // lw
        randomOp(`ALUOP_MEM, 6'b101011, 6'd0, ctlAdd, 2);   // sw
        randomOp(`ALUOP_ITYPE, `OP_ADDI, 6'd0, ctlAdd, 2);
        randomOp(`ALUOP_ITYPE, `OP_ADDIU, 6'd0, ctlAdd, 2);
        randomOp(`ALUOP_ITYPE, `OP_ANDI, 6'd0, ctlAnd, 2);
        randomOp(`ALUOP_ITYPE, `OP_ORI, 6'd0, ctlOr, 2);
        randomOp(`ALUOP_ITYPE, `OP_XORI, 6'd0, ctlXor, 2);
        randomOp(`ALUOP_ITYPE, `OP_SLTI, 6'd0, ctlSlt, 2);
        randomOp(`ALUOP_ITYPE, `OP_SLTIU, 6'd0, ctlSltu, 2);
        randomOp(`ALUOP_ITYPE, `OP_BEQ, 6'd0, ctlSub, 2);
        randomOp(`ALUOP_ITYPE, `OP_BNE, 6'd0, ctlSub, 2);
        randomOp(`ALUOP_ITYPE, `OP_BLEZ, 6'd0, ctlSub, 2);
        randomOp(`ALUOP_ITYPE, `OP_BGTZ, 6'd0, ctlSub, 2);
        randomOp(`ALUOP_ITYPE, `OP_BCOND, 6'd0, ctlSub, 2);
        randomOp(`ALUOP_ITYPE, 6'b111111, 6'd0, ctlNop, 2);
        randomOp(`ALUOP_RTYPE, 6'd0, 6'b111111, ctlNop, 2);

        // shifts, rotate, lui, sign extension
        randomOp(`ALUOP_RTYPE, 6'd0, `FUNCT_SLL, ctlSll, randIters);
        randomOp(`ALUOP_RTYPE, 6'd0, `FUNCT_SRL, ctlSrl, randIters);
        randomOp(`ALUOP_RTYPE, 6'd0, `FUNCT_SRA, ctlSra, randIters);
        randomOp(`ALUOP_RTYPE, 6'd0, `FUNCT_ROTR, ctlRotr, randIters);
        randomOp(`ALUOP_ITYPE, `OP_LUI, 6'd0, ctlLui, randIters);
        randomOp(`ALUOP_RTYPE, 6'd0, `FUNCT_SEB, ctlSeb, randIters);
        randomOp(`ALUOP_RTYPE, 6'd0, `FUNCT_SEH, ctlSeh, randIters);

        // conditional moves
        randomOp(`ALUOP_RTYPE, 6'd0, `FUNCT_MOVZ, ctlMovz, randIters);
        randomOp(`ALUOP_RTYPE, 6'd0, `FUNCT_MOVN, ctlMovn, randIters);

        hiLoSequence();
        divideSequence();

        repeat (3) @(negedge clk);       // let trailing pulses show up
        $display("done: %0d instructions, %0d value errors, %0d protocol errors",
                 opCount, valueErrors, protocolErrors);
        if (valueErrors == 0 && protocolErrors == 0)
        begin
            $display("TB PASSED");
        end
        else
        begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+source
source/execPkg.sv
source/aluControl.sv
source/alu.sv
source/hiLoUnit.sv
source/execUnit.sv
dv/execTb.sv
